//--- dv/rx_scheduler_tb.sv
`timescale 1ns/1ns

module rx_scheduler_tb;

  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 8;
  localparam int LANE_COUNT = 2;
  localparam int DATA_WIDTH = 64;
  localparam int SLOT_W     = $clog2(SLOT_COUNT + 1);
  localparam int CORE_W     = $clog2(CORE_COUNT);
  localparam int KEEP_W     = DATA_WIDTH / 8;
  localparam int TAG_W      = sched_pkg::TAG_WIDTH;
  localparam int DEST_W     = CORE_W + TAG_W;
  localparam int DRIVE      = 2;
  localparam int OFF_CORE   = 2;
  // Reset, idle test, 3 mask changes, 8 control messages, 11 single-beat packets,
  // stalled multi-beat run
  localparam int TEST_CYCLES = 10 + 22 + 3 * 4 + 8 * 6 + 11 * 5 + 40;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic                             clk;
  logic                             rst_r;
  logic [sched_pkg::CTRL_WIDTH-1:0] ctrl_data;
  logic                             ctrl_valid;
  logic [CORE_W-1:0]                ctrl_user;
  logic [CORE_COUNT-1:0]            core_enable;
  logic [LANE_COUNT*DATA_WIDTH-1:0] rx_data;
  logic [LANE_COUNT*KEEP_W-1:0]     rx_keep;
  logic [LANE_COUNT-1:0]            rx_valid;
  logic [LANE_COUNT-1:0]            rx_last;
  logic [LANE_COUNT-1:0]            rx_ready;
  logic [LANE_COUNT*DATA_WIDTH-1:0] core_data;
  logic [LANE_COUNT*KEEP_W-1:0]     core_keep;
  logic [LANE_COUNT-1:0]            core_valid;
  logic [LANE_COUNT-1:0]            core_last;
  logic [LANE_COUNT*DEST_W-1:0]     core_dest;
  logic [LANE_COUNT-1:0]            core_ready;

  // Reference model of the free-slot queues and the descriptor each lane holds
  logic [SLOT_W-1:0]     model_q [CORE_COUNT][$];
  logic [CORE_COUNT-1:0] model_en;
  logic [LANE_COUNT-1:0] need;
  logic [DEST_W-1:0]     held [LANE_COUNT];
  int                    rr;
  int                    checks;
  int                    errors;
  int                    cycles;

  rx_scheduler #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .LANE_COUNT(LANE_COUNT),
    .DATA_WIDTH(DATA_WIDTH)
  ) DUT (
    .clk        (clk),
    .rst_r      (rst_r),
    .ctrl_data  (ctrl_data),
    .ctrl_valid (ctrl_valid),
    .ctrl_user  (ctrl_user),
    .core_enable(core_enable),
    .rx_data    (rx_data),
    .rx_keep    (rx_keep),
    .rx_valid   (rx_valid),
    .rx_last    (rx_last),
    .rx_ready   (rx_ready),
    .core_data  (core_data),
    .core_keep  (core_keep),
    .core_valid (core_valid),
    .core_last  (core_last),
    .core_dest  (core_dest),
    .core_ready (core_ready)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_tag(input string name, input logic [DEST_W-1:0] got,
                           input logic [DEST_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_beat(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_keep(input string name, input logic [KEEP_W-1:0] got,
                            input logic [KEEP_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Core id above the slot number, slot zero-extended
  function automatic logic [DEST_W-1:0] make_tag(input int core, input int slot);
    return {CORE_W'(core), TAG_W'(slot)};
  endfunction

  // Hand out descriptors to waiting lanes, round robin, most slots first
  task automatic model_settle();
    int lane;
    int best;
    while (need != '0) begin
      lane = (rr + 1) % LANE_COUNT;
      while (!need[lane]) begin
        lane = (lane + 1) % LANE_COUNT;
      end
      best = -1;
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (model_en[c] && model_q[c].size() > 0 &&
            (best < 0 || model_q[c].size() > model_q[best].size())) begin
          best = c;
        end
      end
      if (best < 0) break;
      held[lane] = make_tag(best, int'(model_q[best].pop_front()));
      need[lane] = 1'b0;
      rr = lane;
    end
  endtask

  task automatic send_ctrl(input sched_pkg::msg_type_e kind, input int core, input int slot);
    ctrl_data = '0;
    ctrl_data[sched_pkg::CTRL_WIDTH-1 -: sched_pkg::MSG_TYPE_WIDTH] = kind;
    ctrl_data[sched_pkg::SLOT_FIELD_LSB +: 8] = 8'(slot);
    ctrl_user  = CORE_W'(core);
    ctrl_valid = 1'b1;
    @(posedge clk);
    #DRIVE;
    ctrl_valid = 1'b0;
    if (kind == sched_pkg::MSG_SLOT_INIT) begin
      model_q[core].delete();
      for (int s = 1; s <= slot && s <= SLOT_COUNT; s++) begin
        model_q[core].push_back(SLOT_W'(s));
      end
    end else if (kind == sched_pkg::MSG_SLOT_FREE && model_q[core].size() < SLOT_COUNT) begin
      model_q[core].push_back(SLOT_W'(slot));
    end
    model_settle();
    // Two cycles to reach the keeper, then one grant per lane
    repeat (2 + LANE_COUNT) @(posedge clk);
    #DRIVE;
  endtask

  task automatic set_enable(input logic [CORE_COUNT-1:0] mask);
    core_enable = mask;
    model_en    = mask;
    model_settle();
    repeat (2 + LANE_COUNT) @(posedge clk);
    #DRIVE;
  endtask

  task automatic send_packet(input int lane, input int beats, output logic [DEST_W-1:0] tag);
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_W-1:0]     keep;
    int                    b;
    b    = 0;
    tag  = '0;
    data = DATA_WIDTH'({$urandom, $urandom});
    keep = (beats == 1) ? (KEEP_W'($urandom) | KEEP_W'(1)) : '1;
    while (b < beats) begin
      rx_data[lane*DATA_WIDTH +: DATA_WIDTH] = data;
      rx_keep[lane*KEEP_W +: KEEP_W] = keep;
      rx_last[lane] = (b == beats - 1);
      rx_valid[lane] = 1'b1;
      @(negedge clk);
      if (rx_ready[lane]) begin
        check_bit($sformatf("core_valid[%0d]", lane), core_valid[lane], 1'b1);
        check_beat($sformatf("core_data[%0d]", lane),
                   core_data[lane*DATA_WIDTH +: DATA_WIDTH], data);
        check_keep($sformatf("core_keep[%0d]", lane), core_keep[lane*KEEP_W +: KEEP_W], keep);
        check_bit($sformatf("core_last[%0d]", lane), core_last[lane], b == beats - 1);
        if (b == 0) begin
          tag = core_dest[lane*DEST_W +: DEST_W];
        end else begin
          check_tag($sformatf("core_dest[%0d]", lane), core_dest[lane*DEST_W +: DEST_W], tag);
        end
        b++;
        // A stalled beat stays on the lane until it is taken
        data = DATA_WIDTH'({$urandom, $urandom});
        keep = (b == beats - 1) ? (KEEP_W'($urandom) | KEEP_W'(1)) : '1;
      end
      @(posedge clk);
      #DRIVE;
    end
    rx_valid[lane] = 1'b0;
    rx_last[lane]  = 1'b0;
  endtask

  task automatic run_single(input int lane, output logic [DEST_W-1:0] tag);
    send_packet(lane, 1, tag);
    check_tag($sformatf("core_dest[%0d]", lane), tag, held[lane]);
    need[lane] = 1'b1;
    model_settle();
  endtask

  task automatic test_no_slots();
    rx_data[DATA_WIDTH-1:0] = DATA_WIDTH'({$urandom, $urandom});
    rx_valid[0] = 1'b1;
    rx_last[0]  = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check_bit("rx_ready[0]", rx_ready[0], 1'b0);
      check_bit("core_valid[0]", core_valid[0], 1'b0);
    end
    @(posedge clk);
    #DRIVE;
    rx_valid[0] = 1'b0;
    rx_last[0]  = 1'b0;
  endtask

  task automatic test_first_packet();
    logic [DEST_W-1:0] tag;
    set_enable('1);
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 1, 3);
    run_single(0, tag);
    check_tag("core_dest[0]", tag, make_tag(1, 1));
  endtask

  task automatic test_most_slots();
    logic [DEST_W-1:0] tag;
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 0, 2);
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 1, 4);
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 2, 4);
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 3, 1);
    repeat (6) run_single(0, tag);
  endtask

  task automatic test_free_and_mask();
    logic [DEST_W-1:0] tag;
    send_ctrl(sched_pkg::MSG_SLOT_FREE, 3, 5);
    send_ctrl(sched_pkg::MSG_SLOT_FREE, 0, 6);
    // Packet done is not decoded
    send_ctrl(sched_pkg::MSG_PKT_DONE, 1, 2);
    set_enable(~(CORE_COUNT'(1) << OFF_CORE));
    // First packet still uses the descriptor granted before the mask change
    run_single(0, tag);
    repeat (3) begin
      run_single(0, tag);
      checks++;
      if (int'(tag[DEST_W-1 -: CORE_W]) == OFF_CORE) begin
        errors++;
        $display("disabled core %0d was given a packet", OFF_CORE);
      end
    end
  endtask

  task automatic test_both_lanes();
    logic [DEST_W-1:0]     tag_a;
    logic [DEST_W-1:0]     tag_b;
    logic [DEST_W-1:0]     exp_a;
    logic [DEST_W-1:0]     exp_b;
    logic [LANE_COUNT-1:0] done;
    set_enable('1);
    exp_a = held[0];
    exp_b = held[1];
    done  = '0;
    fork
      begin
        send_packet(0, 5, tag_a);
        done[0] = 1'b1;
      end
      begin
        send_packet(1, 4, tag_b);
        done[1] = 1'b1;
      end
      begin
        while (done != '1) begin
          @(posedge clk);
          #DRIVE;
          core_ready = LANE_COUNT'($urandom);
        end
        core_ready = '1;
      end
    join
    // Held descriptors match as a set
    if (tag_a == exp_b) begin
      exp_b = exp_a;
      exp_a = tag_a;
    end
    check_tag("core_dest[0]", tag_a, exp_a);
    check_tag("core_dest[1]", tag_b, exp_b);
    checks++;
    if (tag_a == tag_b) begin
      errors++;
      $display("both lanes carried the same destination tag");
    end
  endtask

  initial begin
    void'($urandom(32'hd7688c50));
    clk         = 1'b0;
    rst_r       = 1'b1;
    ctrl_data   = '0;
    ctrl_valid  = 1'b0;
    ctrl_user   = '0;
    core_enable = '0;
    rx_data     = '0;
    rx_keep     = '0;
    rx_valid    = '0;
    rx_last     = '0;
    core_ready  = '1;
    model_en    = '0;
    need        = '1;
    rr          = LANE_COUNT - 1;
    checks      = 0;
    errors      = 0;
    cycles      = 0;
    repeat (10) @(posedge clk);
    #DRIVE;
    rst_r = 1'b0;
    test_no_slots();
    test_first_packet();
    test_most_slots();
    test_free_and_mask();
    test_both_lanes();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- logic/desc_dispatcher.sv
`timescale 1ns/1ns

module desc_dispatcher #(
  parameter int LANE_COUNT = 2,
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 8,
  localparam int SLOT_W    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_W    = $clog2(CORE_COUNT),
  localparam int TAG_W     = sched_pkg::TAG_WIDTH,
  localparam int DEST_W    = CORE_W + TAG_W,
  localparam int LANE_W    = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1
) (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic [CORE_COUNT-1:0]        core_enable,
  input  logic [CORE_COUNT*SLOT_W-1:0] slot_count,
  input  logic [CORE_COUNT*SLOT_W-1:0] slot_head,
  output logic [CORE_COUNT-1:0]        slot_pop,
  input  logic [LANE_COUNT-1:0]        desc_req,
  output logic                         desc_load,
  output logic [LANE_W-1:0]            desc_lane,
  output logic [DEST_W-1:0]            desc_tag
);

  logic [CORE_COUNT-1:0] enable_r;
  logic [CORE_W-1:0]     best_core;
  logic [SLOT_W-1:0]     best_count;
  logic [SLOT_W-1:0]     best_head;
  logic                  core_hit;
  logic                  lane_hit;
  logic [LANE_W-1:0]     sel_lane;
  logic [LANE_W-1:0]     rr_ptr;
  logic                  grant;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enable_r <= '0;
    end else begin
      enable_r <= core_enable;
    end
  end

  // Most free slots wins, strict compare keeps the lowest index on a tie
  always_comb begin
    best_core  = '0;
    best_count = '0;
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (enable_r[i] && (slot_count[i*SLOT_W +: SLOT_W] > best_count)) begin
        best_core  = CORE_W'(i);
        best_count = slot_count[i*SLOT_W +: SLOT_W];
      end
    end
  end

  assign core_hit  = (best_count != '0);
  assign best_head = slot_head[best_core*SLOT_W +: SLOT_W];

  // Round robin, search starts one past the last granted lane
  always_comb begin
    int idx;
    lane_hit = 1'b0;
    sel_lane = '0;
    for (int k = 1; k <= LANE_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % LANE_COUNT;
      if (!lane_hit && desc_req[idx]) begin
        lane_hit = 1'b1;
        sel_lane = LANE_W'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rr_ptr <= LANE_W'(LANE_COUNT - 1);
    end else if (grant) begin
      rr_ptr <= sel_lane;
    end
  end

  assign grant     = lane_hit && core_hit;
  assign slot_pop  = grant ? (CORE_COUNT'(1) << best_core) : '0;
  assign desc_load = grant;
  assign desc_lane = sel_lane;
  assign desc_tag  = {best_core, {(TAG_W - SLOT_W){1'b0}}, best_head};

endmodule

//--- logic/lane_sequencer.sv
`timescale 1ns/1ns

module lane_sequencer #(
  parameter int LANE_COUNT = 2,
  parameter int DATA_WIDTH = 64,
  parameter int CORE_COUNT = 4,
  localparam int KEEP_W    = DATA_WIDTH / 8,
  localparam int CORE_W    = $clog2(CORE_COUNT),
  localparam int DEST_W    = CORE_W + sched_pkg::TAG_WIDTH,
  localparam int LANE_W    = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1
) (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic [LANE_COUNT*DATA_WIDTH-1:0] rx_data,
  input  logic [LANE_COUNT*KEEP_W-1:0] rx_keep,
  input  logic [LANE_COUNT-1:0]        rx_valid,
  input  logic [LANE_COUNT-1:0]        rx_last,
  output logic [LANE_COUNT-1:0]        rx_ready,
  output logic [LANE_COUNT*DATA_WIDTH-1:0] core_data,
  output logic [LANE_COUNT*KEEP_W-1:0] core_keep,
  output logic [LANE_COUNT-1:0]        core_valid,
  output logic [LANE_COUNT-1:0]        core_last,
  output logic [LANE_COUNT*DEST_W-1:0] core_dest,
  input  logic [LANE_COUNT-1:0]        core_ready,
  output logic [LANE_COUNT-1:0]        desc_req,
  input  logic                         desc_load,
  input  logic [LANE_W-1:0]            desc_lane,
  input  logic [DEST_W-1:0]            desc_tag
);

  for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
    sched_pkg::lane_state_e state;
    logic [DEST_W-1:0]      staged_tag;
    logic [DEST_W-1:0]      active_tag;
    logic                   load;
    logic                   not_stall;
    logic                   accept;
    logic                   pkt_end;

    assign load      = desc_load && (desc_lane == LANE_W'(g));
    assign not_stall = (state != sched_pkg::LANE_STALL);
    assign accept    = rx_valid[g] && core_ready[g] && not_stall;
    assign pkt_end   = accept && rx_last[g];

    always_ff @(posedge clk) begin
      if (rst_r) begin
        state <= sched_pkg::LANE_STALL;
      end else begin
        case (state)
          sched_pkg::LANE_STALL: begin
            if (load) state <= sched_pkg::LANE_FIRST;
          end
          sched_pkg::LANE_FIRST: begin
            if (pkt_end) state <= sched_pkg::LANE_STALL;
            else if (accept) state <= sched_pkg::LANE_WAIT;
          end
          sched_pkg::LANE_WAIT: begin
            if (load && pkt_end) state <= sched_pkg::LANE_FIRST;
            else if (load) state <= sched_pkg::LANE_MID;
            else if (pkt_end) state <= sched_pkg::LANE_STALL;
          end
          sched_pkg::LANE_MID: begin
            if (pkt_end) state <= sched_pkg::LANE_FIRST;
          end
          default: state <= sched_pkg::LANE_STALL;
        endcase
      end
    end

    // Staged tag waits for the next packet, active tag rides the current one
    always_ff @(posedge clk) begin
      if (load) begin
        staged_tag <= desc_tag;
      end
      if ((state == sched_pkg::LANE_FIRST) && accept) begin
        active_tag <= staged_tag;
      end
    end

    assign desc_req[g]   = (state == sched_pkg::LANE_STALL) || (state == sched_pkg::LANE_WAIT);
    assign rx_ready[g]   = core_ready[g] && not_stall;
    assign core_valid[g] = rx_valid[g] && not_stall;
    assign core_last[g]  = rx_last[g];

    assign core_data[g*DATA_WIDTH +: DATA_WIDTH] = rx_data[g*DATA_WIDTH +: DATA_WIDTH];
    assign core_keep[g*KEEP_W +: KEEP_W]         = rx_keep[g*KEEP_W +: KEEP_W];

    // First beat carries the fresh tag before it is latched
    assign core_dest[g*DEST_W +: DEST_W] =
      (state == sched_pkg::LANE_FIRST) ? staged_tag : active_tag;
  end

endmodule

//--- logic/rx_scheduler.sv
`timescale 1ns/1ns

module rx_scheduler #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 8,
  parameter int LANE_COUNT = 2,
  parameter int DATA_WIDTH = 64,
  localparam int SLOT_W    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_W    = $clog2(CORE_COUNT),
  localparam int KEEP_W    = DATA_WIDTH / 8,
  localparam int DEST_W    = CORE_W + sched_pkg::TAG_WIDTH,
  localparam int LANE_W    = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1
) (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic [sched_pkg::CTRL_WIDTH-1:0] ctrl_data,
  input  logic                             ctrl_valid,
  input  logic [CORE_W-1:0]                ctrl_user,
  input  logic [CORE_COUNT-1:0]            core_enable,
  input  logic [LANE_COUNT*DATA_WIDTH-1:0] rx_data,
  input  logic [LANE_COUNT*KEEP_W-1:0]     rx_keep,
  input  logic [LANE_COUNT-1:0]            rx_valid,
  input  logic [LANE_COUNT-1:0]            rx_last,
  output logic [LANE_COUNT-1:0]            rx_ready,
  output logic [LANE_COUNT*DATA_WIDTH-1:0] core_data,
  output logic [LANE_COUNT*KEEP_W-1:0]     core_keep,
  output logic [LANE_COUNT-1:0]            core_valid,
  output logic [LANE_COUNT-1:0]            core_last,
  output logic [LANE_COUNT*DEST_W-1:0]     core_dest,
  input  logic [LANE_COUNT-1:0]            core_ready
);

  logic [CORE_COUNT*SLOT_W-1:0] slot_count;
  logic [CORE_COUNT*SLOT_W-1:0] slot_head;
  logic [CORE_COUNT-1:0]        slot_pop;
  logic [LANE_COUNT-1:0]        desc_req;
  logic                         desc_load;
  logic [LANE_W-1:0]            desc_lane;
  logic [DEST_W-1:0]            desc_tag;

  slot_bank #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) u_slot_bank (
    .clk       (clk),
    .rst_r     (rst_r),
    .ctrl_data (ctrl_data),
    .ctrl_valid(ctrl_valid),
    .ctrl_user (ctrl_user),
    .slot_pop  (slot_pop),
    .slot_head (slot_head),
    .slot_count(slot_count)
  );

  desc_dispatcher #(
    .LANE_COUNT(LANE_COUNT),
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) u_desc_dispatcher (
    .clk        (clk),
    .rst_r      (rst_r),
    .core_enable(core_enable),
    .slot_count (slot_count),
    .slot_head  (slot_head),
    .slot_pop   (slot_pop),
    .desc_req   (desc_req),
    .desc_load  (desc_load),
    .desc_lane  (desc_lane),
    .desc_tag   (desc_tag)
  );

  lane_sequencer #(
    .LANE_COUNT(LANE_COUNT),
    .DATA_WIDTH(DATA_WIDTH),
    .CORE_COUNT(CORE_COUNT)
  ) u_lane_sequencer (
    .clk       (clk),
    .rst_r     (rst_r),
    .rx_data   (rx_data),
    .rx_keep   (rx_keep),
    .rx_valid  (rx_valid),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .core_data (core_data),
    .core_keep (core_keep),
    .core_valid(core_valid),
    .core_last (core_last),
    .core_dest (core_dest),
    .core_ready(core_ready),
    .desc_req  (desc_req),
    .desc_load (desc_load),
    .desc_lane (desc_lane),
    .desc_tag  (desc_tag)
  );

endmodule

//--- logic/sched_pkg.sv
package sched_pkg;

  // Control message layout
  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int SLOT_FIELD_LSB = 16;

  // Slot part of a destination tag, slot widths must fit inside
  localparam int TAG_WIDTH = 5;

  // Message type sits in the top bits of a control message
  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_FREE   = 4'd0,
    MSG_PKT_DONE    = 4'd1,
    MSG_PKT_TO_CORE = 4'd2,
    MSG_SLOT_INIT   = 4'd3
  } msg_type_e;

  // Receive lane states
  // STALL holds the lane until a descriptor is owned
  // FIRST waits for the first beat of a packet
  // WAIT passes beats while the next descriptor is pending
  // MID passes beats with the next descriptor already staged
  typedef enum logic [1:0] {
    LANE_STALL = 2'd0,
    LANE_FIRST = 2'd1,
    LANE_WAIT  = 2'd2,
    LANE_MID   = 2'd3
  } lane_state_e;

endpackage

//--- logic/slot_bank.sv
`timescale 1ns/1ns

module slot_bank #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 8,
  localparam int SLOT_W    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_W    = $clog2(CORE_COUNT)
) (
  input  logic                           clk,
  input  logic                           rst_r,
  input  logic [sched_pkg::CTRL_WIDTH-1:0] ctrl_data,
  input  logic                           ctrl_valid,
  input  logic [CORE_W-1:0]              ctrl_user,
  input  logic [CORE_COUNT-1:0]          slot_pop,
  output logic [CORE_COUNT*SLOT_W-1:0]   slot_head,
  output logic [CORE_COUNT*SLOT_W-1:0]   slot_count
);

  sched_pkg::msg_type_e  msg_type;
  logic                  is_free;
  logic                  is_init;
  logic [CORE_COUNT-1:0] user_hot;
  logic [CORE_COUNT-1:0] enq_v;
  logic [CORE_COUNT-1:0] init_v;
  logic [SLOT_W-1:0]     slot_r;

  assign msg_type = sched_pkg::msg_type_e'(
    ctrl_data[sched_pkg::CTRL_WIDTH-1 -: sched_pkg::MSG_TYPE_WIDTH]);

  assign user_hot = CORE_COUNT'(1) << ctrl_user;

  always_comb begin
    is_free = 1'b0;
    is_init = 1'b0;
    case (msg_type)
      sched_pkg::MSG_SLOT_FREE: is_free = ctrl_valid;
      sched_pkg::MSG_SLOT_INIT: is_init = ctrl_valid;
      // Packet done and packet to core are ignored
      sched_pkg::MSG_PKT_DONE, sched_pkg::MSG_PKT_TO_CORE: begin
      end
      default: begin
      end
    endcase
  end

  // Registered strobes, keeper updates one edge later
  always_ff @(posedge clk) begin
    if (rst_r) begin
      enq_v  <= '0;
      init_v <= '0;
    end else begin
      enq_v  <= {CORE_COUNT{is_free}} & user_hot;
      init_v <= {CORE_COUNT{is_init}} & user_hot;
    end
  end

  // Slot number for free, slot count for init
  always_ff @(posedge clk) begin
    slot_r <= ctrl_data[sched_pkg::SLOT_FIELD_LSB +: SLOT_W];
  end

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_keeper
    slot_keeper #(
      .SLOT_COUNT(SLOT_COUNT)
    ) u_slot_keeper (
      .clk          (clk),
      .rst_r        (rst_r),
      .init_count   (slot_r),
      .init_valid   (init_v[i]),
      .slot_in      (slot_r),
      .slot_in_valid(enq_v[i]),
      .slot_pop     (slot_pop[i]),
      .slot_head    (slot_head[i*SLOT_W +: SLOT_W]),
      .slot_count   (slot_count[i*SLOT_W +: SLOT_W])
    );
  end

endmodule

//--- logic/slot_keeper.sv
`timescale 1ns/1ns

module slot_keeper #(
  parameter int SLOT_COUNT = 8,
  localparam int SLOT_W    = $clog2(SLOT_COUNT + 1),
  localparam int PTR_W     = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1
) (
  input  logic              clk,
  input  logic              rst_r,
  input  logic [SLOT_W-1:0] init_count,
  input  logic              init_valid,
  input  logic [SLOT_W-1:0] slot_in,
  input  logic              slot_in_valid,
  input  logic              slot_pop,
  output logic [SLOT_W-1:0] slot_head,
  output logic [SLOT_W-1:0] slot_count
);

  logic [SLOT_W-1:0] slot_mem [SLOT_COUNT];
  logic [PTR_W-1:0]  head_ptr;
  logic [PTR_W-1:0]  tail_ptr;
  logic [SLOT_W-1:0] init_fill;
  logic              pop_ok;
  logic              enq_ok;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(SLOT_COUNT - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // Never fill past the queue depth
  assign init_fill = (init_count > SLOT_W'(SLOT_COUNT)) ? SLOT_W'(SLOT_COUNT) : init_count;

  assign pop_ok = slot_pop && (slot_count != '0);
  // A full queue still takes a slot when its head leaves in the same cycle
  assign enq_ok = slot_in_valid && ((slot_count != SLOT_W'(SLOT_COUNT)) || pop_ok);

  // Slot numbers start at 1
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slot_mem[i] <= SLOT_W'(i + 1);
      end
    end else if (enq_ok) begin
      slot_mem[tail_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      head_ptr   <= '0;
      tail_ptr   <= '0;
      slot_count <= '0;
    end else if (init_valid) begin
      head_ptr   <= '0;
      tail_ptr   <= (init_fill == SLOT_W'(SLOT_COUNT)) ? '0 : PTR_W'(init_fill);
      slot_count <= init_fill;
    end else begin
      if (pop_ok) begin
        head_ptr <= ptr_inc(head_ptr);
      end
      if (enq_ok) begin
        tail_ptr <= ptr_inc(tail_ptr);
      end
      slot_count <= slot_count + SLOT_W'(enq_ok) - SLOT_W'(pop_ok);
    end
  end

  assign slot_head = slot_mem[head_ptr];

endmodule

//--- run.sh
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
verilator --binary --timing -f vlog.f --top-module rx_scheduler_tb -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && grep -q "All checks passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- vlog.f
logic/sched_pkg.sv
logic/slot_keeper.sv
logic/slot_bank.sv
logic/desc_dispatcher.sv
logic/lane_sequencer.sv
logic/rx_scheduler.sv
dv/rx_scheduler_tb.sv
